/* rtl/booth_pkg.sv */
package booth_pkg;

    // accumulator operation for one booth iteration
    typedef enum logic [1:0] {
        op_pass = 2'b00, // pair 00 or 11
        op_add  = 2'b01, // pair 01, add multiplicand
        op_sub  = 2'b10  // pair 10, subtract multiplicand
    } booth_op_e;

    // sequencer states
    typedef enum logic [1:0] {
        st_idle  = 2'b00,
        st_load  = 2'b01,
        st_run   = 2'b10,
        st_store = 2'b11
    } seq_state_e;

    // apb register map, byte offsets
    localparam logic [7:0] reg_opa    = 8'h00; // multiplicand
    localparam logic [7:0] reg_opb    = 8'h04; // multiplier
    localparam logic [7:0] reg_ctrl   = 8'h08; // bit 0 start, write only
    localparam logic [7:0] reg_status = 8'h0C; // bit 0 busy, bit 1 done
    localparam logic [7:0] reg_result = 8'h10; // signed product

    // status bit positions
    localparam int status_busy_bit = 0;
    localparam int status_done_bit = 1;

endpackage

/* rtl/booth_datapath.sv */
`timescale 1ns/1ps

module booth_datapath #(
    parameter int OPERAND_W = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [OPERAND_W-1:0]   multiplicand,
    input  logic [OPERAND_W-1:0]   multiplier,
    input  logic                   load,
    input  logic                   step,
    input  logic                   store,
    input  booth_pkg::booth_op_e   op,
    output logic [1:0]             booth_bits,
    output logic                   count_done,
    output logic [2*OPERAND_W-1:0] product
);

    localparam int CNT_W = $clog2(OPERAND_W + 1);
    // one guard bit so that subtracting the most negative multiplicand cannot overflow
    localparam int ACC_W = OPERAND_W + 1;
    localparam int CMB_W = ACC_W + OPERAND_W;

    logic [ACC_W-1:0]     mcand;     // sign-extended multiplicand
    logic [ACC_W-1:0]     acc;       // upper half of the combined register
    logic [OPERAND_W-1:0] mplier;    // lower half, consumed one bit per step
    logic                 q_m1;      // Q(-1)
    logic [CNT_W-1:0]     count;
    logic [CNT_W-1:0]     count_inc;
    logic [ACC_W-1:0]     acc_op;    // accumulator after add/sub/pass
    logic [CMB_W-1:0]     combined;
    logic [CMB_W-1:0]     shifted;

    // recoded pair Q0, Q(-1) goes out to the sequencer
    assign booth_bits = {mplier[0], q_m1};

    // add, subtract or pass
    always_comb begin
        case (op)
            booth_pkg::op_add: acc_op = acc + mcand;
            booth_pkg::op_sub: acc_op = acc - mcand;
            default:           acc_op = acc;
        endcase
    end

    // arithmetic right shift of {acc, mplier}
    always_comb begin
        combined = {acc_op, mplier};
        shifted  = {combined[CMB_W-1], combined[CMB_W-1:1]};
    end

    assign count_inc = count + 1'b1;
    // the step now in progress is the last one
    assign count_done = (count_inc == CNT_W'(OPERAND_W));

    // multiplicand, held for the whole run
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mcand <= '0;
        end else if (load) begin
            mcand <= {multiplicand[OPERAND_W-1], multiplicand}; // sign extend into guard bit
        end
    end

    // accumulator, multiplier and Q(-1)
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            acc    <= '0;
            mplier <= '0;
            q_m1   <= 1'b0;
        end else if (load) begin
            acc    <= '0;
            mplier <= multiplier;
            q_m1   <= 1'b0;
        end else if (step) begin
            acc    <= shifted[CMB_W-1:OPERAND_W];
            mplier <= shifted[OPERAND_W-1:0];
            q_m1   <= combined[0]; // bit shifted out
        end
    end

    // iteration counter
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (load) begin
            count <= '0;
        end else if (step) begin
            count <= count_inc;
        end
    end

    // product register, written together with the last step
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            product <= '0;
        end else if (store) begin
            product <= shifted[2*OPERAND_W-1:0]; // guard bit is only sign
        end
    end

endmodule

/* rtl/booth_sequencer.sv */
`timescale 1ns/1ps

module booth_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [1:0]           booth_bits,
    input  logic                 count_done,
    output logic                 load,
    output logic                 step,
    output logic                 store,
    output booth_pkg::booth_op_e op,
    output logic                 busy,
    output logic                 done_pulse
);

    booth_pkg::seq_state_e state;
    booth_pkg::seq_state_e state_nxt;

    // state register
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= booth_pkg::st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            booth_pkg::st_idle: begin
                if (start) begin
                    state_nxt = booth_pkg::st_load;
                end
            end
            booth_pkg::st_load: begin
                state_nxt = booth_pkg::st_run; // single load cycle
            end
            booth_pkg::st_run: begin
                if (count_done) begin
                    state_nxt = booth_pkg::st_store; // last step just issued
                end
            end
            booth_pkg::st_store: begin
                state_nxt = booth_pkg::st_idle;
            end
            default: begin
                state_nxt = booth_pkg::st_idle;
            end
        endcase
    end

    // booth recoding, only the sequencer looks at the pair
    always_comb begin
        op = booth_pkg::op_pass;
        if (state == booth_pkg::st_run) begin
            case (booth_bits)
                2'b01:   op = booth_pkg::op_add;
                2'b10:   op = booth_pkg::op_sub;
                default: op = booth_pkg::op_pass; // 00 and 11
            endcase
        end
    end

    // control strobes straight from the state
    assign load       = (state == booth_pkg::st_load);
    assign step       = (state == booth_pkg::st_run);
    assign store      = step && count_done; // last shift goes to product
    assign done_pulse = (state == booth_pkg::st_store);
    assign busy       = (state != booth_pkg::st_idle); // load through store

endmodule

/* rtl/booth_apb_regs.sv */
`timescale 1ns/1ps

module booth_apb_regs #(
    parameter int OPERAND_W = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic [OPERAND_W-1:0]   multiplicand,
    output logic [OPERAND_W-1:0]   multiplier,
    output logic                   start,
    input  logic                   busy,
    input  logic                   done_pulse,
    input  logic [2*OPERAND_W-1:0] product
);

    logic                   access;   // apb access phase
    logic                   wr;
    logic                   wr_ok;    // write accepted, no error
    logic                   is_opa;
    logic                   is_opb;
    logic                   is_ctrl;
    logic                   is_status;
    logic                   is_result;
    logic                   unknown;
    logic                   wr_ro;    // write to a read-only register
    logic                   wr_busy;  // write refused during a run
    logic                   done;     // sticky done flag
    logic [2*OPERAND_W-1:0] result;
    logic [31:0]            status_rd;

    assign pready = 1'b1; // no wait states

    assign access = psel && penable;
    assign wr     = access && pwrite;

    // address decode
    assign is_opa    = (paddr == booth_pkg::reg_opa);
    assign is_opb    = (paddr == booth_pkg::reg_opb);
    assign is_ctrl   = (paddr == booth_pkg::reg_ctrl);
    assign is_status = (paddr == booth_pkg::reg_status);
    assign is_result = (paddr == booth_pkg::reg_result);
    assign unknown   = !(is_opa || is_opb || is_ctrl || is_status || is_result);

    // error rules
    assign wr_ro   = pwrite && (is_status || is_result);
    assign wr_busy = pwrite && busy && (is_opa || is_opb || is_ctrl);
    assign pslverr = access && (unknown || wr_ro || wr_busy);

    assign wr_ok = wr && !pslverr;

    // one cycle, on the access edge
    assign start = wr_ok && is_ctrl && pwdata[0];

    // operand registers
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            multiplicand <= '0;
            multiplier   <= '0;
        end else if (wr_ok) begin
            if (is_opa) begin
                multiplicand <= pwdata[OPERAND_W-1:0];
            end
            if (is_opb) begin
                multiplier <= pwdata[OPERAND_W-1:0];
            end
        end
    end

    // done stays set until the next accepted start
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b0;
        end else if (done_pulse) begin
            done <= 1'b1;
        end
    end

    // result capture at the end of the store cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            result <= '0;
        end else if (done_pulse) begin
            result <= product;
        end
    end

    always_comb begin
        status_rd = '0;
        status_rd[booth_pkg::status_busy_bit] = busy;
        status_rd[booth_pkg::status_done_bit] = done;
    end

    // read mux, values sign extended to the bus width
    always_comb begin
        prdata = '0;
        if (is_opa) begin
            prdata = 32'($signed(multiplicand));
        end else if (is_opb) begin
            prdata = 32'($signed(multiplier));
        end else if (is_status) begin
            prdata = status_rd;
        end else if (is_result) begin
            prdata = 32'($signed(result));
        end
        // ctrl is write only and reads back zero, unknown addresses too
    end

endmodule

/* rtl/booth_mult_top.sv */
`timescale 1ns/1ps

module booth_mult_top #(
    parameter int OPERAND_W = 16 // product is 2*OPERAND_W
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    // front end <-> datapath
    logic [OPERAND_W-1:0]   multiplicand;
    logic [OPERAND_W-1:0]   multiplier;
    logic [2*OPERAND_W-1:0] product;

    // front end <-> sequencer
    logic start;
    logic busy;
    logic done_pulse;

    // sequencer <-> datapath
    logic                 load;
    logic                 step;
    logic                 store;
    booth_pkg::booth_op_e op;
    logic [1:0]           booth_bits;
    logic                 count_done;

    booth_apb_regs #(
        .OPERAND_W (OPERAND_W)
    ) u_regs (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .start        (start),
        .busy         (busy),
        .done_pulse   (done_pulse),
        .product      (product)
    );

    booth_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .booth_bits (booth_bits),
        .count_done (count_done),
        .load       (load),
        .step       (step),
        .store      (store),
        .op         (op),
        .busy       (busy),
        .done_pulse (done_pulse)
    );

    booth_datapath #(
        .OPERAND_W (OPERAND_W)
    ) u_dp (
        .clk          (clk),
        .rst          (rst),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .load         (load),
        .step         (step),
        .store        (store),
        .op           (op),
        .booth_bits   (booth_bits),
        .count_done   (count_done),
        .product      (product)
    );

endmodule

/* verif/booth_tb_apb.svh */
`ifndef BOOTH_TB_APB_SVH
`define BOOTH_TB_APB_SVH

// every bus task starts and ends 5 ns after a rising edge
task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, output logic err);
    psel    = 1'b1; // setup phase
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #5 penable = 1'b1; // access phase
    @(negedge clk);
    err = pslverr;     // stable mid access
    @(posedge clk);    // access edge
    #5;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #5 penable = 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    if (pready !== 1'b1) begin
        $display("pready was not high in the access phase of a read at %h", addr);
        test_errors++;
    end
    @(posedge clk);
    #5;
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #5;
endtask

// poll status until done, bounded
task automatic wait_done(input string name);
    logic [31:0] data;
    logic        err;
    int          tries;
    data  = '0;
    tries = 0;
    while (data[booth_pkg::status_done_bit] !== 1'b1 && tries < LATENCY + 10) begin
        read_reg(booth_pkg::reg_status, data, err);
        tries++;
    end
    if (data[booth_pkg::status_done_bit] !== 1'b1) begin
        $display("%s: done bit never came up while polling status", name);
        test_errors++;
    end
endtask

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
        $display("FAIL %s expected %h actual %h", name, exp, act);
        test_errors++;
    end
endtask

// one line per finished test
task automatic close_test(input string name);
    if (test_errors == 0) begin
        $display("PASS %s", name);
        pass_count++;
    end else begin
        $display("test %s: %0d check(s) went wrong", name, test_errors);
        fail_count++;
    end
    test_errors = 0;
endtask

`endif

/* verif/booth_tb.sv */
`timescale 1ns/1ps

module booth_tb;

    localparam int OPERAND_W   = 16;
    localparam int LATENCY     = OPERAND_W + 2;         // load, steps, capture
    localparam int CLK_PERIOD  = 100;
    localparam int N_RUNS      = 5 + 200 + 2 + 1 + 2;   // every test counted once
    localparam int WATCHDOG_NS = N_RUNS * (OPERAND_W + 2 + 20) * CLK_PERIOD * 2;

    localparam logic [OPERAND_W-1:0] W_ONE  = OPERAND_W'(1);
    localparam logic [OPERAND_W-1:0] W_MONE = '1;
    localparam logic [OPERAND_W-1:0] W_MIN  = {1'b1, {(OPERAND_W-1){1'b0}}}; // most negative
    localparam logic [OPERAND_W-1:0] W_MAX  = {1'b0, {(OPERAND_W-1){1'b1}}}; // most positive

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    wire  [31:0] prdata;
    wire         pready;
    wire         pslverr;

    int          test_errors;   // checks failed in the running test
    int          pass_count;
    int          fail_count;
    logic [31:0] lfsr;
    logic [31:0] last_product;  // model value the result register should hold

    booth_mult_top #(
        .OPERAND_W (OPERAND_W)
    ) uut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    `include "booth_tb_apb.svh"

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // 32-bit galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // signed product of the sign-extended operands
    function automatic logic [31:0] model_product(input logic [OPERAND_W-1:0] a,
                                                  input logic [OPERAND_W-1:0] b);
        longint sa;
        longint sb;
        longint p;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        p  = sa * sb;
        return p[31:0];
    endfunction

    // operands then start with all three writes accepted
    task automatic start_run(input string name, input logic [OPERAND_W-1:0] a,
                             input logic [OPERAND_W-1:0] b);
        logic err;
        write_reg(booth_pkg::reg_opa, 32'(a), err);
        check_value({name, " opa pslverr"}, 32'h0, 32'(err));
        write_reg(booth_pkg::reg_opb, 32'(b), err);
        check_value({name, " opb pslverr"}, 32'h0, 32'(err));
        write_reg(booth_pkg::reg_ctrl, 32'h1, err);
        check_value({name, " start pslverr"}, 32'h0, 32'(err));
    endtask

    task automatic run_product(input string name, input logic [OPERAND_W-1:0] a,
                               input logic [OPERAND_W-1:0] b);
        logic [31:0] data;
        logic        err;
        start_run(name, a, b);
        read_reg(booth_pkg::reg_status, data, err);
        check_value({name, " status after start"}, 32'h1, data); // busy, done cleared
        wait_done(name);
        last_product = model_product(a, b);
        read_reg(booth_pkg::reg_result, data, err);
        check_value({name, " result"}, last_product, data);
        close_test(name);
    endtask

    // status sampled a fixed number of cycles after the start access edge
    task automatic check_latency(input string name, input int wait_n, input logic [31:0] exp);
        logic [31:0] bits;
        logic [31:0] data;
        logic        err;
        logic [OPERAND_W-1:0] a;
        logic [OPERAND_W-1:0] b;
        take_bits(OPERAND_W, bits);
        a = bits[OPERAND_W-1:0];
        take_bits(OPERAND_W, bits);
        b = bits[OPERAND_W-1:0];
        start_run(name, a, b);
        wait_cycles(wait_n);
        read_reg(booth_pkg::reg_status, data, err); // sampled wait_n+1 cycles after start
        check_value({name, " status"}, exp, data);
        wait_done(name);
        last_product = model_product(a, b);
        read_reg(booth_pkg::reg_result, data, err);
        check_value({name, " result"}, last_product, data);
        close_test(name);
    endtask

    // every write during a run is refused and the first product survives
    task automatic check_refusal();
        logic [31:0] data;
        logic        err;
        start_run("refusal_busy", 16'h1234, 16'hFEDC);
        write_reg(booth_pkg::reg_opa, 32'h0000_7FFF, err);
        check_value("refusal_busy opa pslverr", 32'h1, 32'(err));
        write_reg(booth_pkg::reg_opb, 32'h0000_0002, err);
        check_value("refusal_busy opb pslverr", 32'h1, 32'(err));
        write_reg(booth_pkg::reg_ctrl, 32'h1, err);
        check_value("refusal_busy start pslverr", 32'h1, 32'(err));
        wait_done("refusal_busy");
        last_product = model_product(16'h1234, 16'hFEDC);
        read_reg(booth_pkg::reg_result, data, err);
        check_value("refusal_busy result", last_product, data);
        read_reg(booth_pkg::reg_opa, data, err); // operand registers untouched
        check_value("refusal_busy opa kept", 32'(16'h1234), 32'(data[OPERAND_W-1:0]));
        read_reg(booth_pkg::reg_opb, data, err);
        check_value("refusal_busy opb kept", 32'(16'hFEDC), 32'(data[OPERAND_W-1:0]));
        close_test("refusal_busy");
    endtask

    task automatic check_errors();
        logic [7:0]  bad_addr [3] = '{8'h14, 8'h02, 8'hFC};
        logic [31:0] data;
        logic        err;
        foreach (bad_addr[i]) begin
            read_reg(bad_addr[i], data, err);
            check_value($sformatf("errors read %h pslverr", bad_addr[i]), 32'h1, 32'(err));
            check_value($sformatf("errors read %h data", bad_addr[i]), 32'h0, data);
        end
        write_reg(booth_pkg::reg_status, 32'h3, err);
        check_value("errors write status pslverr", 32'h1, 32'(err));
        write_reg(booth_pkg::reg_result, 32'hDEAD_BEEF, err);
        check_value("errors write result pslverr", 32'h1, 32'(err));
        write_reg(8'h40, 32'h1, err);
        check_value("errors write unknown pslverr", 32'h1, 32'(err));
        read_reg(booth_pkg::reg_result, data, err); // refused write left it alone
        check_value("errors result kept", last_product, data);
        close_test("error_responses");
    endtask

    task automatic check_reset_state();
        logic [7:0]  addr [5] = '{booth_pkg::reg_opa, booth_pkg::reg_opb, booth_pkg::reg_ctrl,
                                  booth_pkg::reg_status, booth_pkg::reg_result};
        logic [31:0] data;
        logic        err;
        foreach (addr[i]) begin
            read_reg(addr[i], data, err);
            check_value($sformatf("reset read %h data", addr[i]), 32'h0, data);
            check_value($sformatf("reset read %h pslverr", addr[i]), 32'h0, 32'(err));
        end
        close_test("reset_state");
    endtask

    // hard stop if the sequence hangs
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [31:0]          bits;
        logic [OPERAND_W-1:0] a;
        logic [OPERAND_W-1:0] b;
        rst          = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        test_errors  = 0;
        pass_count   = 0;
        fail_count   = 0;
        last_product = '0;
        lfsr         = 32'd75656;
        repeat (8) @(posedge clk);
        #5 rst = 1'b1;

        check_reset_state();

        take_bits(OPERAND_W, bits);
        run_product("corner_zero_x", '0, bits[OPERAND_W-1:0]);
        run_product("corner_one_mone", W_ONE, W_MONE);
        run_product("corner_min_min", W_MIN, W_MIN);
        run_product("corner_max_min", W_MAX, W_MIN);
        run_product("corner_mone_mone", W_MONE, W_MONE);

        for (int i = 0; i < 200; i++) begin
            take_bits(OPERAND_W, bits);
            a = bits[OPERAND_W-1:0];
            take_bits(OPERAND_W, bits);
            b = bits[OPERAND_W-1:0];
            run_product($sformatf("random_%0d", i), a, b);
        end

        check_latency("latency_before_done", LATENCY - 2, 32'h1); // busy, not done yet
        check_latency("latency_done", LATENCY - 1, 32'h2);        // done, idle
        check_refusal();
        check_errors();

        $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+verif
rtl/booth_pkg.sv
rtl/booth_datapath.sv
rtl/booth_sequencer.sv
rtl/booth_apb_regs.sv
rtl/booth_mult_top.sv
verif/booth_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module booth_mult_top -f list.f
	verilator --lint-only --timing --top-module booth_tb -f list.f

sim:
	verilator --binary --timing -j 0 --top-module booth_tb -f list.f -o booth_sim
	./obj_dir/booth_sim | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
